// File: idct_cfg.svh
/*
 * IDCT engine configuration
 * Block geometry, SRAM layout, pass shifts and SRAM read latency
 */
`ifndef IDCT_CFG_SVH
`define IDCT_CFG_SVH

`define IDCT_N 8

// SRAM word addresses
`define IDCT_SPRIME_BASE 76800
`define IDCT_OUT_BASE 0

// Arithmetic right shifts applied after each pass
`define IDCT_PASS1_SHIFT 8
`define IDCT_PASS2_SHIFT 16

`define IDCT_SRAM_LATENCY 2

// Default frame size in blocks
`define IDCT_BLOCK_COLS 40
`define IDCT_BLOCK_ROWS 30

`endif

// File: idct_pkg.sv
/*
 * IDCT shared types
 * Bus widths, pair packing and the state encodings
 */
`default_nettype none

package idct_pkg;

	typedef logic [17:0] sram_addr_t;
	typedef logic [15:0] sram_word_t;

	typedef logic signed [15:0] coef_t;   // S' value or coefficient
	typedef logic [31:0] pair_t;          // High half holds the lower index
	typedef logic signed [31:0] acc_t;
	typedef logic [7:0] pixel_t;
	typedef logic [4:0] bram_addr_t;      // 32 pair words per block

	// Block sequencer
	typedef enum logic [2:0] {
		PH_IDLE,
		PH_FETCH,
		PH_PASS1,
		PH_PASS2,
		PH_STORE,
		PH_DONE
	} phase_t;

	typedef enum logic {
		PASS_ROW,   // T = S' * C^T
		PASS_COL    // S = C * T
	} pass_t;

	typedef enum logic [1:0] {
		MAC_IDLE,
		MAC_RUN,
		MAC_DRAIN
	} mac_state_t;

endpackage

`default_nettype wire

// File: dp_ram.sv
/*
 * Dual-port block RAM
 * One write port, one registered read port
 */
`timescale 1ns/1ps
`default_nettype none

module dp_ram #(
	parameter int DEPTH = 32,
	parameter int WIDTH = 32
) (
	input  logic                     CLOCK_50_I,
	input  logic                     wr_en,
	input  logic [$clog2(DEPTH)-1:0] wr_addr,
	input  logic [WIDTH-1:0]         wr_data,
	input  logic [$clog2(DEPTH)-1:0] rd_addr,
	output logic [WIDTH-1:0]         rd_data
);

	logic [WIDTH-1:0] mem [DEPTH];

	always_ff @(posedge CLOCK_50_I) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
		rd_data <= mem[rd_addr];   // One cycle read latency
	end

endmodule

`default_nettype wire

// File: coef_rom.sv
/*
 * IDCT coefficient ROM
 * Word 4x+j holds C[x][2j] in the high half and C[x][2j+1] in the low half
 */
`timescale 1ns/1ps
`default_nettype none

module coef_rom (
	input  logic                 CLOCK_50_I,
	input  idct_pkg::bram_addr_t addr,
	output idct_pkg::pair_t      data
);
	import idct_pkg::*;

	// C[x][u] at index 8x+u, scaled by 4096
	localparam coef_t C_TAB [64] = '{
		1448,  2009,  1892,  1703,  1448,  1138,   784,   400,
		1448,  1703,   784,  -400, -1448, -2009, -1892, -1138,
		1448,  1138,  -784, -2009, -1448,   400,  1892,  1703,
		1448,   400, -1892, -1138,  1448,  1703,  -784, -2009,
		1448,  -400, -1892,  1138,  1448, -1703,  -784,  2009,
		1448, -1138,  -784,  2009, -1448,  -400,  1892, -1703,
		1448, -1703,   784,   400, -1448,  2009, -1892,  1138,
		1448, -2009,  1892, -1703,  1448, -1138,   784,  -400
	};

	// Registered like dp_ram so both operands line up
	always_ff @(posedge CLOCK_50_I) begin
		data <= {C_TAB[{addr, 1'b0}], C_TAB[{addr, 1'b1}]};
	end

endmodule

`default_nettype wire

// File: block_fetch.sv
/*
 * Block fetch
 * Reads one 8x8 block of S' from SRAM and packs sample pairs into block RAM
 */
`timescale 1ns/1ps
`default_nettype none

`include "idct_cfg.svh"

module block_fetch #(
	parameter int BLOCK_COLS = `IDCT_BLOCK_COLS
) (
	input  logic                 CLOCK_50_I,
	input  logic                 resetn,
	input  logic                 go,
	input  logic [7:0]           block_col,
	input  logic [7:0]           block_row,
	output idct_pkg::sram_addr_t sram_address,
	input  idct_pkg::sram_word_t sram_read_data,
	output logic                 ram_wr_en,
	output idct_pkg::bram_addr_t ram_wr_addr,
	output idct_pkg::pair_t      ram_wr_data,
	output logic                 done
);
	import idct_pkg::*;

	localparam int LAT = `IDCT_SRAM_LATENCY;
	localparam int ROW_STEP = `IDCT_N * `IDCT_N * BLOCK_COLS;   // One row of blocks
	localparam sram_addr_t STRIDE = sram_addr_t'(`IDCT_N * BLOCK_COLS);

	logic active;
	logic [5:0] cnt;                // Sample index, row-major
	sram_addr_t row_base;
	logic [LAT-1:0] vld_pipe;
	logic [5:0] idx_pipe [LAT];
	logic [5:0] idx_out;
	sram_word_t even_buf;

	assign sram_address = row_base + sram_addr_t'(cnt[2:0]);
	assign idx_out = idx_pipe[LAT-1];   // Index of the sample now on the bus

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			active <= 1'b0;
			cnt <= '0;
			row_base <= '0;
			vld_pipe <= '0;
			ram_wr_en <= 1'b0;
			done <= 1'b0;
		end else begin
			vld_pipe[0] <= active;
			for (int i = 1; i < LAT; i++)
				vld_pipe[i] <= vld_pipe[i-1];
			ram_wr_en <= vld_pipe[LAT-1] && idx_out[0];   // Write on odd samples
			done <= vld_pipe[LAT-1] && (idx_out == 6'd63);
			if (go) begin
				active <= 1'b1;
				cnt <= '0;
				row_base <= sram_addr_t'(`IDCT_SPRIME_BASE + block_row * ROW_STEP
					+ block_col * `IDCT_N);
			end else if (active) begin
				cnt <= cnt + 6'd1;
				if (cnt[2:0] == 3'd7)
					row_base <= row_base + STRIDE;   // Next image row
				if (cnt == 6'd63)
					active <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLOCK_50_I) begin
		idx_pipe[0] <= cnt;
		for (int i = 1; i < LAT; i++)
			idx_pipe[i] <= idx_pipe[i-1];
		if (vld_pipe[LAT-1]) begin
			if (!idx_out[0]) begin
				even_buf <= sram_read_data;
			end else begin
				ram_wr_addr <= idx_out[5:1];
				ram_wr_data <= {even_buf, sram_read_data};
			end
		end
	end

endmodule

`default_nettype wire

// File: matrix_mult.sv
/*
 * Dual-MAC matrix engine
 * Runs one IDCT pass over a block, two products per cycle, pairs results per word
 */
`timescale 1ns/1ps
`default_nettype none

`include "idct_cfg.svh"

module matrix_mult (
	input  logic                 CLOCK_50_I,
	input  logic                 resetn,
	input  logic                 go,
	input  idct_pkg::pass_t      pass,
	output idct_pkg::bram_addr_t src_addr,
	input  idct_pkg::pair_t      src_data,
	output idct_pkg::bram_addr_t coef_addr,
	input  idct_pkg::pair_t      coef_data,
	output logic                 wr_en,
	output idct_pkg::bram_addr_t wr_addr,
	output idct_pkg::pair_t      wr_data,
	output logic                 done
);
	import idct_pkg::*;

	mac_state_t state;
	logic [7:0] step;               // {outer, inner, k}
	logic [2:0] outer;
	logic [2:0] inner;
	logic [1:0] k;
	bram_addr_t dst_addr;

	// Tags travelling alongside the RAM read and operand stages
	logic v1, v2;
	logic l1, l2;                   // Last k of an output
	logic f1, f2;                   // First k, restart the sum
	logic h1, h2;                   // Odd member of a pair
	bram_addr_t a1, a2;

	coef_t op_s_hi, op_s_lo;
	coef_t op_c_hi, op_c_lo;
	acc_t prod_hi, prod_lo;
	acc_t acc, sum, scaled;
	coef_t hold;

	assign outer = step[7:5];
	assign inner = step[4:2];
	assign k = step[1:0];

	// Inner counter runs along the pair direction of the destination RAM
	// Transposed T lets both passes share one address pattern
	assign src_addr = {inner, k};
	assign coef_addr = {outer, k};
	assign dst_addr = {outer, inner[2:1]};

	assign prod_hi = op_s_hi * op_c_hi;
	assign prod_lo = op_s_lo * op_c_lo;
	assign sum = (f2 ? acc_t'(0) : acc) + prod_hi + prod_lo;
	assign scaled = (pass == PASS_ROW) ? (sum >>> `IDCT_PASS1_SHIFT)
		: (sum >>> `IDCT_PASS2_SHIFT);

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			state <= MAC_IDLE;
			step <= '0;
			v1 <= 1'b0;
			v2 <= 1'b0;
			wr_en <= 1'b0;
			done <= 1'b0;
		end else begin
			v1 <= (state == MAC_RUN);
			v2 <= v1;
			wr_en <= v2 && l2 && h2;
			done <= v2 && !v1;   // Final accumulation of the block
			case (state)
			MAC_IDLE: begin
				if (go) begin
					step <= '0;
					state <= MAC_RUN;
				end
			end
			MAC_RUN: begin
				step <= step + 8'd1;
				if (step == 8'hff)
					state <= MAC_DRAIN;
			end
			MAC_DRAIN: begin
				if (v2 && !v1)
					state <= MAC_IDLE;
			end
			default: state <= MAC_IDLE;
			endcase
		end
	end

	always_ff @(posedge CLOCK_50_I) begin
		l1 <= (k == 2'd3);
		f1 <= (k == 2'd0);
		h1 <= inner[0];
		a1 <= dst_addr;
		l2 <= l1;
		f2 <= f1;
		h2 <= h1;
		a2 <= a1;
		op_s_hi <= src_data[31:16];
		op_s_lo <= src_data[15:0];
		op_c_hi <= coef_data[31:16];
		op_c_lo <= coef_data[15:0];
		if (v2)
			acc <= sum;
		if (v2 && l2) begin
			if (!h2) begin
				hold <= scaled[15:0];   // Even index waits for its partner
			end else begin
				wr_addr <= a2;
				wr_data <= {hold, scaled[15:0]};
			end
		end
	end

endmodule

`default_nettype wire

// File: block_store.sv
/*
 * Block store
 * Saturates S to 8-bit pixels and writes pixel pairs to the SRAM
 */
`timescale 1ns/1ps
`default_nettype none

`include "idct_cfg.svh"

module block_store (
	input  logic                 CLOCK_50_I,
	input  logic                 resetn,
	input  logic                 go,
	input  logic [11:0]          block_index,
	output idct_pkg::bram_addr_t ram_rd_addr,
	input  idct_pkg::pair_t      ram_rd_data,
	output idct_pkg::sram_addr_t sram_address,
	output idct_pkg::sram_word_t sram_write_data,
	output logic                 sram_we_n,
	output logic                 done
);
	import idct_pkg::*;

	logic active;
	bram_addr_t rd_cnt;
	bram_addr_t rd_idx;             // Word now on the RAM output
	logic rd_vld;

	function automatic pixel_t saturate(input coef_t v);
		if (v < 0)
			return 8'd0;
		else if (v > 255)
			return 8'd255;
		else
			return v[7:0];
	endfunction

	assign ram_rd_addr = rd_cnt;

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			active <= 1'b0;
			rd_cnt <= '0;
			rd_vld <= 1'b0;
			sram_we_n <= 1'b1;
			done <= 1'b0;
		end else begin
			rd_vld <= active;
			sram_we_n <= !rd_vld;
			done <= rd_vld && (rd_idx == 5'd31);
			if (go) begin
				active <= 1'b1;
				rd_cnt <= '0;
			end else if (active) begin
				rd_cnt <= rd_cnt + 5'd1;
				if (rd_cnt == 5'd31)
					active <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLOCK_50_I) begin
		rd_idx <= rd_cnt;
		if (rd_vld) begin
			sram_address <= sram_addr_t'(`IDCT_OUT_BASE + {block_index, rd_idx});
			// Even x goes to the high byte
			sram_write_data <= {saturate(ram_rd_data[31:16]), saturate(ram_rd_data[15:0])};
		end
	end

endmodule

`default_nettype wire

// File: idct_top.sv
/*
 * 2-D 8x8 IDCT engine top
 * Walks the block grid and runs fetch, two matrix passes and store per block
 */
`timescale 1ns/1ps
`default_nettype none

`include "idct_cfg.svh"

module idct_top #(
	parameter int BLOCK_COLS = `IDCT_BLOCK_COLS,
	parameter int BLOCK_ROWS = `IDCT_BLOCK_ROWS
) (
	input  logic                 CLOCK_50_I,
	input  logic                 resetn,
	input  logic                 start,
	output logic                 finish,
	output idct_pkg::sram_addr_t sram_address,
	output idct_pkg::sram_word_t sram_write_data,
	output logic                 sram_we_n,
	input  idct_pkg::sram_word_t sram_read_data
);
	import idct_pkg::*;

	localparam int RAM_DEPTH = `IDCT_N * `IDCT_N / 2;
	localparam int NUM_BLOCKS = BLOCK_COLS * BLOCK_ROWS;

	phase_t phase;
	logic [7:0] block_col, block_row;
	logic [11:0] block_index;
	logic fetch_go, mult_go, store_go;
	logic fetch_done, mult_done, store_done;
	pass_t mult_pass;

	sram_addr_t fetch_sram_address, store_sram_address;
	logic store_we_n;

	logic sp_wr_en, mult_wr_en, t_wr_en, s_wr_en;
	bram_addr_t sp_wr_addr, mult_wr_addr, src_addr, coef_addr, s_rd_addr;
	pair_t sp_wr_data, mult_wr_data, src_data, coef_data;
	pair_t sp_rd_data, t_rd_data, s_rd_data;

	// Block sequencer, one block at a time in raster order
	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			phase <= PH_IDLE;
			block_col <= '0;
			block_row <= '0;
			block_index <= '0;
			fetch_go <= 1'b0;
			mult_go <= 1'b0;
			store_go <= 1'b0;
			finish <= 1'b0;
		end else begin
			fetch_go <= 1'b0;
			mult_go <= 1'b0;
			store_go <= 1'b0;
			case (phase)
			PH_IDLE, PH_DONE: begin
				if (start) begin
					block_col <= '0;
					block_row <= '0;
					block_index <= '0;
					finish <= 1'b0;
					fetch_go <= 1'b1;
					phase <= PH_FETCH;
				end
			end
			PH_FETCH: begin
				if (fetch_done) begin
					mult_go <= 1'b1;
					phase <= PH_PASS1;
				end
			end
			PH_PASS1: begin
				if (mult_done) begin
					mult_go <= 1'b1;
					phase <= PH_PASS2;
				end
			end
			PH_PASS2: begin
				if (mult_done) begin
					store_go <= 1'b1;
					phase <= PH_STORE;
				end
			end
			PH_STORE: begin
				if (store_done) begin
					block_index <= block_index + 12'd1;
					if (block_index == 12'(NUM_BLOCKS - 1)) begin
						finish <= 1'b1;
						phase <= PH_DONE;
					end else begin
						if (block_col == 8'(BLOCK_COLS - 1)) begin
							block_col <= '0;
							block_row <= block_row + 8'd1;
						end else begin
							block_col <= block_col + 8'd1;
						end
						fetch_go <= 1'b1;
						phase <= PH_FETCH;
					end
				end
			end
			default: phase <= PH_IDLE;
			endcase
		end
	end

	// Only the store phase writes, every other phase reads
	assign sram_address = (phase == PH_STORE) ? store_sram_address : fetch_sram_address;
	assign sram_we_n = (phase == PH_STORE) ? store_we_n : 1'b1;

	assign mult_pass = (phase == PH_PASS1) ? PASS_ROW : PASS_COL;
	assign src_data = (phase == PH_PASS1) ? sp_rd_data : t_rd_data;
	assign t_wr_en = mult_wr_en && (phase == PH_PASS1);
	assign s_wr_en = mult_wr_en && (phase == PH_PASS2);

	block_fetch #(
		.BLOCK_COLS(BLOCK_COLS)
	) u_block_fetch (
		.CLOCK_50_I(CLOCK_50_I), .resetn(resetn), .go(fetch_go),
		.block_col(block_col), .block_row(block_row),
		.sram_address(fetch_sram_address), .sram_read_data(sram_read_data),
		.ram_wr_en(sp_wr_en), .ram_wr_addr(sp_wr_addr), .ram_wr_data(sp_wr_data),
		.done(fetch_done)
	);

	dp_ram #(.DEPTH(RAM_DEPTH), .WIDTH($bits(pair_t))) u_sprime_ram (
		.CLOCK_50_I(CLOCK_50_I), .wr_en(sp_wr_en), .wr_addr(sp_wr_addr),
		.wr_data(sp_wr_data), .rd_addr(src_addr), .rd_data(sp_rd_data)
	);

	dp_ram #(.DEPTH(RAM_DEPTH), .WIDTH($bits(pair_t))) u_t_ram (
		.CLOCK_50_I(CLOCK_50_I), .wr_en(t_wr_en), .wr_addr(mult_wr_addr),
		.wr_data(mult_wr_data), .rd_addr(src_addr), .rd_data(t_rd_data)
	);

	dp_ram #(.DEPTH(RAM_DEPTH), .WIDTH($bits(pair_t))) u_s_ram (
		.CLOCK_50_I(CLOCK_50_I), .wr_en(s_wr_en), .wr_addr(mult_wr_addr),
		.wr_data(mult_wr_data), .rd_addr(s_rd_addr), .rd_data(s_rd_data)
	);

	coef_rom u_coef_rom (
		.CLOCK_50_I(CLOCK_50_I), .addr(coef_addr), .data(coef_data)
	);

	matrix_mult u_matrix_mult (
		.CLOCK_50_I(CLOCK_50_I), .resetn(resetn), .go(mult_go), .pass(mult_pass),
		.src_addr(src_addr), .src_data(src_data),
		.coef_addr(coef_addr), .coef_data(coef_data),
		.wr_en(mult_wr_en), .wr_addr(mult_wr_addr), .wr_data(mult_wr_data),
		.done(mult_done)
	);

	block_store u_block_store (
		.CLOCK_50_I(CLOCK_50_I), .resetn(resetn), .go(store_go),
		.block_index(block_index),
		.ram_rd_addr(s_rd_addr), .ram_rd_data(s_rd_data),
		.sram_address(store_sram_address), .sram_write_data(sram_write_data),
		.sram_we_n(store_we_n), .done(store_done)
	);

endmodule

`default_nettype wire

// File: idct_chk.sv
/*
 * IDCT top checker
 * Reset state, no SRAM writes after finish, writes kept below the S' area
 */
`timescale 1ns/1ps
`default_nettype none

`include "idct_cfg.svh"

module idct_chk (
	input logic                 CLOCK_50_I,
	input logic                 resetn,
	input logic                 finish,
	input logic                 sram_we_n,
	input idct_pkg::sram_addr_t sram_address
);
	import idct_pkg::*;

	localparam sram_addr_t SPRIME_BASE = sram_addr_t'(`IDCT_SPRIME_BASE);

	int fail_count = 0;   // Failed assertions so far

	// Idle outputs in the first cycle out of reset
	reset_idle: assert property (@(posedge CLOCK_50_I)
		$rose(resetn) |-> (sram_we_n && !finish))
	else begin
		fail_count++;
		$error("SRAM write enable or finish active right after reset");
	end

	quiet_after_finish: assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		finish |-> sram_we_n)
	else begin
		fail_count++;
		$error("SRAM written while finish is high");
	end

	// Output writes must never reach the coefficient area
	write_below_sprime: assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		!sram_we_n |-> (sram_address < SPRIME_BASE))
	else begin
		fail_count++;
		$error("SRAM write at or above the S' base address");
	end

endmodule

`default_nettype wire

// File: idct_scoreboard.sv
/*
 * IDCT scoreboard
 * Reference 2-D IDCT of each frame, checks every SRAM write and reports per test
 */
`timescale 1ns/1ps
`default_nettype none

`include "idct_cfg.svh"

module idct_scoreboard #(
	parameter int BLOCK_COLS = 4,
	parameter int BLOCK_ROWS = 2
) (
	input logic                 CLOCK_50_I,
	input logic                 resetn,
	input logic                 start,
	input logic                 finish,
	input idct_pkg::sram_addr_t sram_address,
	input idct_pkg::sram_word_t sram_write_data,
	input logic                 sram_we_n
);
	import idct_pkg::*;

	localparam int N = `IDCT_N;
	localparam int NUM_BLOCKS = BLOCK_COLS * BLOCK_ROWS;
	localparam int IMG_W = N * BLOCK_COLS;
	localparam int IMG_SIZE = IMG_W * N * BLOCK_ROWS;
	localparam int WORDS_PER_BLOCK = N * N / 2;
	localparam int NUM_WORDS = NUM_BLOCKS * WORDS_PER_BLOCK;

	int img [IMG_SIZE];              // S' samples of the current frame
	sram_word_t exp_word [NUM_WORDS];
	bit written [NUM_WORDS];
	int blk_writes [NUM_BLOCKS];
	int blk_err [NUM_BLOCKS];
	int frame_no = 0;
	int frames_done = 0;
	int quiet_err = 0;               // Errors outside a running frame
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	bit frame_active = 1'b0;
	logic finish_d = 1'b0;

	// C[x][u] scaled by 4096, straight from the cosine definition
	function automatic int coef(input int x, input int u);
		real c;
		real v;
		c = (u == 0) ? $sqrt(1.0 / 8.0) : 0.5;
		v = 4096.0 * c * $cos((2 * x + 1) * u * 3.14159265358979 / 16.0);
		return (v >= 0.0) ? $rtoi(v + 0.5) : -$rtoi(0.5 - v);
	endfunction

	function automatic logic [7:0] clamp_pixel(input int v);
		if (v < 0)
			return 8'd0;
		if (v > 255)
			return 8'd255;
		return 8'(v);
	endfunction

	task automatic load_coef(input int idx, input int value);
		img[idx] = value;
	endtask

	task automatic record_test(input string name, input bit ok);
		tests_run++;
		if (!ok)
			tests_failed++;
		$display("%s: %s", name, ok ? "PASS" : "FAIL");
	endtask

	task automatic close_quiet_test(input string name);
		record_test(name, quiet_err == 0);
		quiet_err = 0;
	endtask

	task automatic build_expected(input int frame_id);
		int br;
		int bc;
		int acc;
		int t [N][N];
		int s [N][N];
		frame_no = frame_id;
		for (int b = 0; b < NUM_BLOCKS; b++) begin
			br = b / BLOCK_COLS;
			bc = b % BLOCK_COLS;
			blk_writes[b] = 0;
			blk_err[b] = 0;
			// Pass 1 along each row of S'
			for (int r = 0; r < N; r++) begin
				for (int x = 0; x < N; x++) begin
					acc = 0;
					for (int u = 0; u < N; u++)
						acc += img[(N * br + r) * IMG_W + N * bc + u] * coef(x, u);
					t[r][x] = acc >>> `IDCT_PASS1_SHIFT;
				end
			end
			// Pass 2 down each column of T
			for (int y = 0; y < N; y++) begin
				for (int x = 0; x < N; x++) begin
					acc = 0;
					for (int v = 0; v < N; v++)
						acc += coef(y, v) * t[v][x];
					s[y][x] = acc >>> `IDCT_PASS2_SHIFT;
				end
			end
			for (int y = 0; y < N; y++) begin
				for (int j = 0; j < N / 2; j++)
					exp_word[b * WORDS_PER_BLOCK + y * N / 2 + j] =
						{clamp_pixel(s[y][2 * j]), clamp_pixel(s[y][2 * j + 1])};
			end
		end
		for (int i = 0; i < NUM_WORDS; i++)
			written[i] = 1'b0;
	endtask

	task automatic check_write(input int addr, input sram_word_t data);
		int idx;
		int b;
		idx = addr - `IDCT_OUT_BASE;
		if (!frame_active) begin
			$display("ERROR %0d ns: SRAM write to address %0d while no frame runs", $time, addr);
			quiet_err++;
			errors++;
		end else if (idx < 0 || idx >= NUM_WORDS) begin
			$display("ERROR %0d ns: SRAM write to address %0d outside the output area",
				$time, addr);
			errors++;
		end else begin
			b = idx / WORDS_PER_BLOCK;
			if (written[idx]) begin
				$display("ERROR %0d ns: output word %0d written twice", $time, idx);
				blk_err[b]++;
				errors++;
			end
			written[idx] = 1'b1;
			if (data !== exp_word[idx]) begin
				$display("FAIL %0d ns sram_write_data at address %0d: expected %h, got %h",
					$time, addr, exp_word[idx], data);
				blk_err[b]++;
				errors++;
			end
			blk_writes[b]++;
			if (blk_writes[b] == WORDS_PER_BLOCK)
				record_test($sformatf("frame %0d block %0d", frame_no, b), blk_err[b] == 0);
		end
	endtask

	task automatic end_frame();
		int missing;
		missing = 0;
		for (int i = 0; i < NUM_WORDS; i++)
			if (!written[i])
				missing++;
		if (missing != 0) begin
			$display("ERROR %0d ns: frame %0d finished with %0d output words never written",
				$time, frame_no, missing);
			errors++;
		end
		record_test($sformatf("frame %0d output coverage", frame_no), missing == 0);
		frame_active = 1'b0;
		frames_done++;
	endtask

	// Negedge sampling, everything here settled since the last rising edge
	always @(negedge CLOCK_50_I) begin
		if (resetn) begin
			if (sram_we_n === 1'b0)
				check_write(int'(sram_address), sram_write_data);
			if (frame_active && finish === 1'b1 && finish_d !== 1'b1) begin
				end_frame();
			end else if (!frame_active && finish !== (frames_done > 0)) begin
				$display("FAIL %0d ns finish: expected %0b, got %0b",
					$time, frames_done > 0, finish);
				quiet_err++;
				errors++;
			end
			if (start === 1'b1)
				frame_active = 1'b1;
			finish_d = finish;
		end
	end

endmodule

`default_nettype wire

// File: idct_tb.sv
/*
 * IDCT engine testbench
 * SRAM model with random S' frames, two frames run and checked by the scoreboard
 */
`timescale 1ns/1ps
`default_nettype none

`include "idct_cfg.svh"

module idct_tb;
	import idct_pkg::*;

	localparam int BLOCK_COLS = 4;
	localparam int BLOCK_ROWS = 2;
	localparam int NUM_BLOCKS = BLOCK_COLS * BLOCK_ROWS;
	localparam int IMG_W = `IDCT_N * BLOCK_COLS;
	localparam int NUM_FRAMES = 2;
	localparam int CLK_PERIOD = 100;
	localparam int TIMEOUT_NS = (NUM_BLOCKS * 700 * NUM_FRAMES + 100) * CLK_PERIOD;
	// Reset idle, then per frame every block, coverage and the idle window
	localparam int EXPECTED_TESTS = 1 + NUM_FRAMES * (NUM_BLOCKS + 2);

	logic CLOCK_50_I;
	logic resetn;
	logic start;
	logic finish;
	sram_addr_t sram_address;
	sram_word_t sram_write_data;
	logic sram_we_n;
	sram_word_t sram_read_data;

	sram_word_t sram_mem [2**18];
	sram_word_t rd_d0, rd_d1;   // SRAM read pipeline
	int frame;

	idct_top #(
		.BLOCK_COLS(BLOCK_COLS),
		.BLOCK_ROWS(BLOCK_ROWS)
	) u_idct_top (
		.CLOCK_50_I(CLOCK_50_I), .resetn(resetn), .start(start), .finish(finish),
		.sram_address(sram_address), .sram_write_data(sram_write_data),
		.sram_we_n(sram_we_n), .sram_read_data(sram_read_data)
	);

	idct_scoreboard #(
		.BLOCK_COLS(BLOCK_COLS),
		.BLOCK_ROWS(BLOCK_ROWS)
	) u_scoreboard (
		.CLOCK_50_I(CLOCK_50_I), .resetn(resetn), .start(start), .finish(finish),
		.sram_address(sram_address), .sram_write_data(sram_write_data),
		.sram_we_n(sram_we_n)
	);

	bind idct_top idct_chk u_idct_chk (
		.CLOCK_50_I(CLOCK_50_I), .resetn(resetn), .finish(finish),
		.sram_we_n(sram_we_n), .sram_address(sram_address)
	);

	always #(CLK_PERIOD / 2) CLOCK_50_I = ~CLOCK_50_I;

	// Address seen here is the one presented at the next edge, data due two edges later
	always @(posedge CLOCK_50_I) begin
		#1;
		if (sram_we_n === 1'b0)
			sram_mem[sram_address] = sram_write_data;
		sram_read_data = rd_d1;
		rd_d1 = rd_d0;
		rd_d0 = sram_mem[sram_address];
	end

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge CLOCK_50_I);
		#1;
	endtask

	task automatic pulse_start();
		start = 1'b1;
		wait_cycles(1);
		start = 1'b0;
	endtask

	task automatic wait_finish();
		do
			@(negedge CLOCK_50_I);
		while (finish !== 1'b1);
		wait_cycles(1);
	endtask

	// Random S' in -512..511, one large positive and one large negative DC-only block
	task automatic load_frame(input int frame_id);
		int pos_dc;
		int neg_dc;
		int idx;
		int v;
		pos_dc = $urandom % NUM_BLOCKS;
		neg_dc = (pos_dc + 1 + $urandom % (NUM_BLOCKS - 1)) % NUM_BLOCKS;
		for (int blk = 0; blk < NUM_BLOCKS; blk++) begin
			for (int r = 0; r < `IDCT_N; r++) begin
				for (int u = 0; u < `IDCT_N; u++) begin
					idx = (`IDCT_N * (blk / BLOCK_COLS) + r) * IMG_W
						+ `IDCT_N * (blk % BLOCK_COLS) + u;
					if (blk == pos_dc || blk == neg_dc)
						v = (r == 0 && u == 0) ? 3000 + int'($urandom % 1000) : 0;
					else
						v = int'($urandom % 1024) - 512;
					if (blk == neg_dc)
						v = -v;
					sram_mem[`IDCT_SPRIME_BASE + idx] = sram_word_t'(v);
					u_scoreboard.load_coef(idx, v);
				end
			end
		end
		u_scoreboard.build_expected(frame_id);
	endtask

	initial begin
		#(TIMEOUT_NS);
		$display("Watchdog: the run did not finish within %0d ns", TIMEOUT_NS);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		void'($urandom(32'hdbd3));
		CLOCK_50_I = 1'b0;
		resetn = 1'b0;
		start = 1'b0;
		sram_read_data = '0;
		rd_d0 = '0;
		rd_d1 = '0;
		repeat (4) @(posedge CLOCK_50_I);
		#1 resetn = 1'b1;
		wait_cycles(20);   // No start yet
		u_scoreboard.close_quiet_test("reset idle");
		for (frame = 1; frame <= NUM_FRAMES; frame++) begin
			load_frame(frame);
			pulse_start();
			wait_finish();
			wait_cycles(50);
			u_scoreboard.close_quiet_test($sformatf("frame %0d idle after finish", frame));
		end
		$display("Tests run %0d of %0d, failed %0d, errors %0d, assertion failures %0d",
			u_scoreboard.tests_run, EXPECTED_TESTS, u_scoreboard.tests_failed,
			u_scoreboard.errors, u_idct_top.u_idct_chk.fail_count);
		if (u_scoreboard.errors == 0 && u_scoreboard.tests_failed == 0
				&& u_scoreboard.tests_run == EXPECTED_TESTS
				&& u_idct_top.u_idct_chk.fail_count == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
+incdir+.
idct_pkg.sv
dp_ram.sv
coef_rom.sv
block_fetch.sv
matrix_mult.sv
block_store.sv
idct_top.sv
idct_chk.sv
idct_scoreboard.sv
idct_tb.sv
